// File: all.f
+incdir+.
pe_pkg.sv
dsp_cfg_if.sv
dsp_lane.sv
simd_alu.sv
pe_control.sv
pe_top.sv
tb_pe_top.sv

// File: tb_pe_top.sv
`include "pe_defs.svh"

module tb_pe_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam realtime CLK_PERIOD   = 4ns;
    localparam int      RESET_CYCLES = 5;
    // 48 reg, 24 imm, 8 nop, 40 burst, 6 reset and 30 gap slots
    localparam int      N_INST       = 156;
    localparam int      IDLE_MAX     = 90 + 6 * 6 + 8;     // gaps, drains, mid reset
    localparam int      WATCH_CYCLES = N_INST + IDLE_MAX + 20 + RESET_CYCLES;

    typedef struct {
        logic [`INST_WIDTH-1:0] inst;
        logic [`DATA_WIDTH-1:0] ld;
        logic [`DATA_WIDTH-1:0] pe;
        logic [`DATA_WIDTH-1:0] wb;
        int                     issue_cyc;
    } exp_t;

    logic                   clk;
    logic                   arst_n;
    logic                   inst_valid;
    logic [`INST_WIDTH-1:0] inst;
    logic [`DATA_WIDTH-1:0] din_ld;
    logic [`DATA_WIDTH-1:0] din_pe;
    logic [`DATA_WIDTH-1:0] din_wb;
    logic [`DATA_WIDTH-1:0] result;
    logic                   result_valid;

    exp_t exp_q[$];
    int   cycle = 0;

    pe_top dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [`DATA_WIDTH-1:0] select_operand(input logic [1:0] sel,
                                                              input exp_t e);
        case (sel)
            2'b00:   return e.ld;
            2'b01:   return e.pe;
            2'b10:   return e.wb;
            default: return '0;     // zero source
        endcase
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] ref_result(input exp_t e);
        logic [2:0]             op;
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        logic [`LANE_WIDTH-1:0] x;
        logic [`LANE_WIDTH-1:0] y;
        logic [`DATA_WIDTH-1:0] r;
        op = e.inst[26:24];
        a  = select_operand(e.inst[63:62], e);
        if (op[2])
            b = {`NUM_LANES{e.inst[7:0]}};     // immediate broadcast
        else
            b = select_operand(e.inst[1:0], e);
        for (int i = 0; i < `NUM_LANES; i++) begin
            x = a[i*`LANE_WIDTH +: `LANE_WIDTH];
            y = b[i*`LANE_WIDTH +: `LANE_WIDTH];
            case (op[1:0])
                2'b01:   r[i*`LANE_WIDTH +: `LANE_WIDTH] = x + y;
                2'b10:   r[i*`LANE_WIDTH +: `LANE_WIDTH] = x - y;
                2'b11:   r[i*`LANE_WIDTH +: `LANE_WIDTH] = x * y;  // low byte kept
                default: r[i*`LANE_WIDTH +: `LANE_WIDTH] = '0;
            endcase
        end
        return r;
    endfunction

    task automatic stop_failed();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic idle_slot();
        @(posedge clk);
        #0.5ns;
        inst_valid = 1'b0;
        din_ld     = $urandom;     // noise on the data ports
        din_pe     = $urandom;
        din_wb     = $urandom;
    endtask

    task automatic issue_inst(input logic [1:0] a_sel, input logic [2:0] op,
                              input logic [7:0] low8);
        exp_t e;
        @(posedge clk);
        #0.5ns;
        e.inst        = {$urandom, $urandom};   // reserved bits random
        e.inst[63:62] = a_sel;
        e.inst[26:24] = op;
        e.inst[7:0]   = low8;
        e.ld          = $urandom;
        e.pe          = $urandom;
        e.wb          = $urandom;
        e.issue_cyc   = cycle + 1;              // sampled at the next edge
        inst       = e.inst;
        din_ld     = e.ld;
        din_pe     = e.pe;
        din_wb     = e.wb;
        inst_valid = 1'b1;
        exp_q.push_back(e);
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
            idle_slot();
        repeat (`PE_LATENCY) idle_slot();      // catch stray pulses
    endtask

    //////////////////////////////////////////////////////////////////////
    // comparator sampled mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin : compare
        exp_t                   e;
        logic [`DATA_WIDTH-1:0] exp_val;
        if (result_valid === 1'b1) begin
            assert (arst_n)
            else begin
                $display("ERROR at %0t: result_valid high during reset", $time);
                stop_failed();
            end
            assert (exp_q.size() > 0)
            else begin
                $display("ERROR at %0t: result_valid with no instruction in flight", $time);
                stop_failed();
            end
            e       = exp_q.pop_front();
            exp_val = ref_result(e);
            assert (cycle + 1 == e.issue_cyc + `PE_LATENCY)    // next edge samples it
            else begin
                $display("MISMATCH time=%0t signal=result_valid cycle expected=%0d got=%0d",
                         $time, e.issue_cyc + `PE_LATENCY, cycle + 1);
                stop_failed();
            end
            assert (result === exp_val)
            else begin
                $display("MISMATCH time=%0t signal=result expected=%h got=%h",
                         $time, exp_val, result);
                stop_failed();
            end
        end
    end

    initial begin : watchdog
        #(WATCH_CYCLES * CLK_PERIOD);
        $display("ERROR: timeout, %0d results missing", exp_q.size());
        stop_failed();
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic [7:0] low8;
        void'($urandom(32'h7681));
        clk        = 1'b0;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        din_ld     = '0;
        din_pe     = '0;
        din_wb     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5ns;
        arst_n = 1'b1;
        repeat (`PE_LATENCY) idle_slot();

        // register forms with every a_sel / b_sel pair
        for (int op = 1; op <= 3; op++)
            for (int as = 0; as < 4; as++)
                for (int bs = 0; bs < 4; bs++) begin
                    low8 = $urandom;
                    low8[1:0] = bs;
                    issue_inst(as, op, low8);
                end
        drain();

        // immediate forms
        for (int op = 5; op <= 7; op++)
            for (int as = 0; as < 8; as++)
                issue_inst(as % 4, op, $urandom);
        drain();

        // both NOP codes
        for (int as = 0; as < 4; as++) begin
            issue_inst(as, 3'b000, $urandom);
            issue_inst(as, 3'b100, $urandom);
        end
        drain();

        // back-to-back with mixed opcodes
        repeat (40) issue_inst($urandom, $urandom, $urandom);
        drain();

        // reset in the middle of a burst
        repeat (6) issue_inst($urandom, $urandom, $urandom);
        @(posedge clk);
        #0.5ns;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        exp_q.delete();     // in-flight results are cancelled
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5ns;
        arst_n = 1'b1;
        repeat (`PE_LATENCY) idle_slot();

        // random gaps between instructions
        repeat (30) begin
            repeat ($urandom_range(0, 3)) idle_slot();
            issue_inst($urandom, $urandom, $urandom);
        end
        drain();

        if (exp_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("ERROR: %0d results never arrived", exp_q.size());
            stop_failed();
        end
    end

endmodule

// File: pe_top.sv
`include "pe_defs.svh"

module pe_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   inst_valid,
    input  logic [`INST_WIDTH-1:0] inst,
    input  logic [`DATA_WIDTH-1:0] din_ld,
    input  logic [`DATA_WIDTH-1:0] din_pe,
    input  logic [`DATA_WIDTH-1:0] din_wb,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   result_valid
);

    logic [`DATA_WIDTH-1:0] a_data;
    logic [`DATA_WIDTH-1:0] b_data;
    logic                   op_valid;

    dsp_cfg_if cfg_if ();

    // decode and operand select
    pe_control ctrl_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .din_ld     (din_ld),
        .din_pe     (din_pe),
        .din_wb     (din_wb),
        .a_data     (a_data),
        .b_data     (b_data),
        .op_valid   (op_valid),
        .cfg        (cfg_if.ctrl)
    );

    // four lanes
    simd_alu alu_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .a_data       (a_data),
        .b_data       (b_data),
        .op_valid     (op_valid),
        .cfg          (cfg_if.lane),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// File: pe_control.sv
`include "pe_defs.svh"

module pe_control (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   inst_valid,
    input  pe_pkg::pe_inst_u       inst,
    input  logic [`DATA_WIDTH-1:0] din_ld,
    input  logic [`DATA_WIDTH-1:0] din_pe,
    input  logic [`DATA_WIDTH-1:0] din_wb,
    output logic [`DATA_WIDTH-1:0] a_data,
    output logic [`DATA_WIDTH-1:0] b_data,
    output logic                   op_valid,
    dsp_cfg_if.ctrl                cfg
);
    import pe_pkg::*;

    pe_opcode_e              opcode;
    logic                    is_imm;
    logic [`DATA_WIDTH-1:0]  a_next;
    logic [`DATA_WIDTH-1:0]  b_next;
    logic [4*`NUM_LANES-1:0] alumode_d;
    logic [5*`NUM_LANES-1:0] inmode_d;
    logic [7*`NUM_LANES-1:0] opmode_d;
    logic                    cea_d;     // same value for A2 and B2
    logic                    usemult_d;

    function automatic logic [`DATA_WIDTH-1:0] src_pick(
        input pe_src_e                sel,
        input logic [`DATA_WIDTH-1:0] ld,
        input logic [`DATA_WIDTH-1:0] pe,
        input logic [`DATA_WIDTH-1:0] wb
    );
        case (sel)
            SRC_LD:  return ld;
            SRC_PE:  return pe;
            SRC_WB:  return wb;
            default: return '0;
        endcase
    endfunction

    assign opcode = inst.reg_f.opcode;      // same field in both views
    assign is_imm = opcode[2];

    //////////////////////////////////////////////////////////////////////
    // operand select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        a_next = src_pick(inst.reg_f.a_sel, din_ld, din_pe, din_wb);
        if (is_imm) begin
            b_next = {`NUM_LANES{inst.imm_f.imm8}};
        end else begin
            b_next = src_pick(inst.reg_f.b_sel, din_ld, din_pe, din_wb);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // opcode decode, one config copy per lane
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        alumode_d = '0;     // NOP unless matched
        inmode_d  = '0;
        opmode_d  = '0;
        cea_d     = 1'b0;
        usemult_d = 1'b0;
        case (opcode)
            OP_ADD, OP_ADDI: begin
                opmode_d = {`NUM_LANES{7'b0110011}};
                cea_d    = 1'b1;
            end
            OP_SUB, OP_SUBI: begin
                alumode_d = {`NUM_LANES{4'b0011}};
                opmode_d  = {`NUM_LANES{7'b0110011}};
                cea_d     = 1'b1;
            end
            OP_MUL, OP_MULI: begin
                inmode_d  = {`NUM_LANES{5'b10001}};    // A1/B1 into the multiplier
                opmode_d  = {`NUM_LANES{7'b0000101}};
                usemult_d = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_valid    <= 1'b0;
            cfg.alumode <= '0;
            cfg.inmode  <= '0;
            cfg.opmode  <= '0;
            cfg.cea2    <= '0;
            cfg.ceb2    <= '0;
            cfg.usemult <= '0;
        end else begin
            op_valid <= inst_valid;
            if (inst_valid) begin
                cfg.alumode <= alumode_d;
                cfg.inmode  <= inmode_d;
                cfg.opmode  <= opmode_d;
                cfg.cea2    <= {`NUM_LANES{cea_d}};
                cfg.ceb2    <= {`NUM_LANES{cea_d}};
                cfg.usemult <= {`NUM_LANES{usemult_d}};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            a_data <= a_next;
            b_data <= b_next;
        end
    end

    // multiply path never loads A2 in the lanes
    a_mult_excl: assert property (@(posedge clk) disable iff (!arst_n)
        (cfg.usemult & cfg.cea2) == '0);

endmodule

// File: simd_alu.sv
`include "pe_defs.svh"

module simd_alu (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`DATA_WIDTH-1:0] a_data,
    input  logic [`DATA_WIDTH-1:0] b_data,
    input  logic                   op_valid,
    dsp_cfg_if.lane                cfg,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   result_valid
);

    logic mid_valid;    // operands sit in A2/B2/M

    // valid pipeline, one bit per lane stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mid_valid    <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            mid_valid    <= op_valid;
            result_valid <= mid_valid;
        end
    end

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        dsp_lane lane_i (
            .clk     (clk),
            .arst_n  (arst_n),
            .a       (a_data[i*`LANE_WIDTH +: `LANE_WIDTH]),
            .b       (b_data[i*`LANE_WIDTH +: `LANE_WIDTH]),
            .alumode (cfg.alumode[4*i +: 4]),
            .inmode  (cfg.inmode[5*i +: 5]),
            .opmode  (cfg.opmode[7*i +: 7]),
            .cea2    (cfg.cea2[i]),
            .ceb2    (cfg.ceb2[i]),
            .usemult (cfg.usemult[i]),
            .adv     ({mid_valid, op_valid}),
            .p       (result[i*`LANE_WIDTH +: `LANE_WIDTH])    // byte i
        );
    end

    // control register is the first of the PE_LATENCY stages
    valid_latency: assert property (@(posedge clk) disable iff (!arst_n)
        op_valid |-> ##(`PE_LATENCY-1) result_valid);

endmodule

// File: dsp_lane.sv
`include "pe_defs.svh"

module dsp_lane (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`LANE_WIDTH-1:0] a,
    input  logic [`LANE_WIDTH-1:0] b,
    input  logic [3:0]             alumode,
    input  logic [4:0]             inmode,
    input  logic [6:0]             opmode,
    input  logic                   cea2,
    input  logic                   ceb2,
    input  logic                   usemult,
    input  logic [1:0]             adv,     // bit 0 middle stage, bit 1 P stage
    output logic [`LANE_WIDTH-1:0] p
);

    logic [`LANE_WIDTH-1:0]   a2;
    logic [`LANE_WIDTH-1:0]   b2;
    logic [`LANE_WIDTH-1:0]   m;
    logic [`LANE_WIDTH-1:0]   prod;
    logic [3:0]               alumode_q;
    logic [6:0]               opmode_q;
    logic                     usemult_q;
    logic [`LANE_WIDTH-1:0]   p_d;

    assign prod = a * b;    // low byte only

    //////////////////////////////////////////////////////////////////////
    // middle stage with A2/B2 or M
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (adv[0]) begin
            if (cea2)
                a2 <= a;
            if (ceb2)
                b2 <= b;
            if (usemult && inmode[0] && inmode[4])
                m <= prod;
        end
    end

    // config travels with the data
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alumode_q <= '0;
            opmode_q  <= '0;
            usemult_q <= 1'b0;
        end else if (adv[0]) begin
            alumode_q <= alumode;
            opmode_q  <= opmode;
            usemult_q <= usemult;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output stage
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (opmode_q == '0) begin
            p_d = '0;
        end else if (usemult_q) begin
            p_d = m;
        end else begin
            case (alumode_q)
                4'b0000: p_d = a2 + b2;
                4'b0011: p_d = a2 - b2;
                default: p_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            p <= '0;
        else if (adv[1])
            p <= p_d;
    end

    // decoder only issues add and subtract modes
    alumode_legal: assert property (@(posedge clk) disable iff (!arst_n)
        adv[0] |-> alumode inside {4'b0000, 4'b0011});

endmodule

// File: dsp_cfg_if.sv
`include "pe_defs.svh"

// per-lane DSP configuration, lane i in the i-th field of each word
interface dsp_cfg_if;

    logic [4*`NUM_LANES-1:0] alumode;
    logic [5*`NUM_LANES-1:0] inmode;
    logic [7*`NUM_LANES-1:0] opmode;
    logic [`NUM_LANES-1:0]   cea2;
    logic [`NUM_LANES-1:0]   ceb2;
    logic [`NUM_LANES-1:0]   usemult;

    // decoder side
    modport ctrl (
        output alumode, inmode, opmode,
        output cea2, ceb2, usemult
    );

    // SIMD ALU side
    modport lane (
        input alumode, inmode, opmode,
        input cea2, ceb2, usemult
    );

endinterface

// File: pe_pkg.sv
`include "pe_defs.svh"

package pe_pkg;

    // bit 2 marks the immediate forms
    typedef enum logic [2:0] {
        OP_NOP  = 3'b000,
        OP_ADD  = 3'b001,
        OP_SUB  = 3'b010,
        OP_MUL  = 3'b011,
        OP_NOPI = 3'b100,
        OP_ADDI = 3'b101,
        OP_SUBI = 3'b110,
        OP_MULI = 3'b111
    } pe_opcode_e;

    // operand source, shared by the A select and register-form B select
    typedef enum logic [1:0] {
        SRC_LD   = 2'b00,   // load data
        SRC_PE   = 2'b01,   // neighbour data
        SRC_WB   = 2'b10,   // write-back data
        SRC_ZERO = 2'b11
    } pe_src_e;

    typedef struct packed {
        pe_src_e    a_sel;      // 63:62
        logic [34:0] rsvd_hi;
        pe_opcode_e opcode;     // 26:24
        logic [21:0] rsvd_lo;
        pe_src_e    b_sel;      // 1:0
    } pe_reg_inst_t;

    typedef struct packed {
        pe_src_e                a_sel;
        logic [34:0]            rsvd_hi;
        pe_opcode_e             opcode;
        logic [15:0]            rsvd_lo;
        logic [`LANE_WIDTH-1:0] imm8;   // broadcast to all lanes
    } pe_imm_inst_t;

    typedef union packed {
        pe_reg_inst_t reg_f;
        pe_imm_inst_t imm_f;
    } pe_inst_u;

endpackage

// File: pe_defs.svh
`ifndef PE_DEFS_SVH
`define PE_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// datapath
//////////////////////////////////////////////////////////////////////

// data ports and result word
`define DATA_WIDTH 32

// one lane of the SIMD ALU
`define LANE_WIDTH 8
`define NUM_LANES  4

//////////////////////////////////////////////////////////////////////
// instruction and timing
//////////////////////////////////////////////////////////////////////

`define INST_WIDTH 64

// cycles from inst_valid to result_valid
`define PE_LATENCY 3

`endif
